// File: verilog/i2c_pkg.sv
`default_nettype none

package i2c_pkg;
	localparam int REG_W = 16; // host register width
	localparam int DIV_W = 16; // step divider width

	typedef enum logic [7:0] {
		idle, wait_release,
		start_a, start_b,
		addr_shift, addr_high, addr_low,
		rd_setup, rd_high, rd_low, byte_next,
		stop_a, stop_b, stop_c,
		done
	} i2c_state_t;

	typedef enum logic {
		op_read  = 1'b0, // two byte read
		op_probe = 1'b1  // address only, write bit
	} i2c_op_t;

	typedef enum logic [1:0] {
		reg_ctrl  = 2'd0, // status on read
		reg_slave = 2'd1,
		reg_div   = 2'd2,
		reg_data  = 2'd3
	} reg_addr_t;
endpackage

`default_nettype wire

// File: verilog/i2c_bit_timer.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_bit_timer (
	input  wire                       PT_CK,
	input  wire                       RESET_N,
	input  wire                       enable,
	input  wire [i2c_pkg::DIV_W-1:0]  div,
	output logic                      step
);

	logic [i2c_pkg::DIV_W-1:0] cnt;

	// one step every div+1 clocks while enabled
	always_ff @(posedge PT_CK) begin
		if (!RESET_N) begin
			cnt  <= '0;
			step <= 1'b0;
		end else if (!enable) begin
			cnt  <= div; // parked at reload value
			step <= 1'b0;
		end else if (cnt == '0) begin
			cnt  <= div; // div picked up here
			step <= 1'b1;
		end else begin
			cnt  <= cnt - 1'b1;
			step <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verilog/i2c_read_master.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_read_master (
	input  wire                    PT_CK,
	input  wire                    RESET_N,
	input  wire                    step,
	input  wire                    go,
	input  wire i2c_pkg::i2c_op_t  op,
	input  wire [6:0]              slave_address,
	input  wire                    sdai,
	output logic                   sdao,
	output logic                   sclo,
	output logic                   end_ok,
	output logic                   ack_ok,
	output logic [15:0]            data16,
	output logic                   busy
);

	i2c_pkg::i2c_state_t state;
	i2c_pkg::i2c_op_t    op_q;
	logic [8:0]          shift;     // address, r/w, released ack slot
	logic [3:0]          bit_cnt;
	logic                last_byte;

	assign busy = (state != i2c_pkg::idle);

	always_ff @(posedge PT_CK) begin
		if (!RESET_N) begin
			state     <= i2c_pkg::idle;
			op_q      <= i2c_pkg::op_read;
			shift     <= '1;
			bit_cnt   <= '0;
			last_byte <= 1'b0;
			sdao      <= 1'b1;
			sclo      <= 1'b1;
			end_ok    <= 1'b1;
			ack_ok    <= 1'b0;
			data16    <= '0;
		end else if (state == i2c_pkg::idle) begin
			// timer is stopped here, so no step gating
			if (go)
				state <= i2c_pkg::wait_release;
		end else if (step) begin
			case (state)
				i2c_pkg::wait_release: begin
					if (!go) begin
						sdao    <= 1'b0; // start, sda falls while scl high
						end_ok  <= 1'b0;
						op_q    <= op;
						shift   <= {slave_address, (op == i2c_pkg::op_read), 1'b1};
						bit_cnt <= '0;
						data16  <= '1; // released bus reads ones
						state   <= i2c_pkg::start_a;
					end
				end

				i2c_pkg::start_a: begin
					sclo  <= 1'b0;
					state <= i2c_pkg::start_b;
				end

				i2c_pkg::start_b: begin
					sdao  <= shift[8]; // first address bit, scl low
					shift <= {shift[7:0], 1'b1};
					state <= i2c_pkg::addr_shift;
				end

				i2c_pkg::addr_shift: begin
					sclo    <= 1'b1;
					bit_cnt <= bit_cnt + 1'b1;
					state   <= i2c_pkg::addr_high;
				end

				i2c_pkg::addr_high: begin
					sclo <= 1'b0;
					if (bit_cnt == 4'd9)
						ack_ok <= !sdai; // slave pulls low to ack
					state <= i2c_pkg::addr_low;
				end

				i2c_pkg::addr_low: begin
					if (bit_cnt == 4'd9) begin
						bit_cnt <= '0;
						if (op_q == i2c_pkg::op_read) begin
							sdao      <= 1'b1;
							last_byte <= 1'b0;
							state     <= i2c_pkg::rd_setup;
						end else begin
							sdao  <= 1'b0; // probe goes straight to stop
							state <= i2c_pkg::stop_a;
						end
					end else begin
						sdao  <= shift[8];
						shift <= {shift[7:0], 1'b1};
						state <= i2c_pkg::addr_shift;
					end
				end

				i2c_pkg::rd_setup: begin
					sclo    <= 1'b1;
					bit_cnt <= bit_cnt + 1'b1;
					state   <= i2c_pkg::rd_high;
				end

				i2c_pkg::rd_high: begin
					sclo <= 1'b0;
					if (bit_cnt != 4'd9)
						data16 <= {data16[14:0], sdai}; // msb first
					state <= i2c_pkg::rd_low;
				end

				i2c_pkg::rd_low: begin
					if (bit_cnt == 4'd9) begin
						sdao  <= 1'b1;
						state <= i2c_pkg::byte_next;
					end else begin
						// ack after byte 0, nack after byte 1
						sdao  <= (bit_cnt == 4'd8) ? last_byte : 1'b1;
						state <= i2c_pkg::rd_setup;
					end
				end

				i2c_pkg::byte_next: begin
					bit_cnt <= '0;
					if (last_byte) begin
						sdao  <= 1'b0;
						state <= i2c_pkg::stop_a;
					end else begin
						last_byte <= 1'b1;
						state     <= i2c_pkg::rd_setup;
					end
				end

				i2c_pkg::stop_a: begin
					sclo  <= 1'b1;
					state <= i2c_pkg::stop_b;
				end

				i2c_pkg::stop_b: begin
					sdao  <= 1'b1; // stop, sda rises while scl high
					state <= i2c_pkg::stop_c;
				end

				i2c_pkg::stop_c: begin
					end_ok <= 1'b1;
					state  <= i2c_pkg::done;
				end

				i2c_pkg::done: begin
					state <= i2c_pkg::idle;
				end

				default: begin
					sdao   <= 1'b1;
					sclo   <= 1'b1;
					end_ok <= 1'b1;
					state  <= i2c_pkg::idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/sensor_regs.sv
`timescale 1ns/10ps
`default_nettype none

module sensor_regs #(
	parameter logic [i2c_pkg::DIV_W-1:0] DIV_RESET = 16'd24
) (
	input  wire                        PT_CK,
	input  wire                        RESET_N,
	input  wire                        reg_wr,
	input  wire                        reg_rd,
	input  wire i2c_pkg::reg_addr_t    reg_addr,
	input  wire [i2c_pkg::REG_W-1:0]   reg_wdata,
	output logic [i2c_pkg::REG_W-1:0]  reg_rdata,
	input  wire                        end_ok,
	input  wire                        busy,
	input  wire [i2c_pkg::REG_W-1:0]   data16,
	input  wire                        ack_ok,
	output logic                       go,
	output i2c_pkg::i2c_op_t           op,
	output logic [6:0]                 slave_address,
	output logic [i2c_pkg::DIV_W-1:0]  div
);

	logic                       end_ok_q;
	logic                       end_rise;
	logic                       start_wr;
	logic                       done;
	logic                       ack_q;
	logic [i2c_pkg::REG_W-1:0]  sample;
	logic [i2c_pkg::REG_W-1:0]  rd_mux;

	assign end_rise = end_ok && !end_ok_q;
	assign start_wr = reg_wr && (reg_addr == i2c_pkg::reg_ctrl) && reg_wdata[0] && !busy;

	// configuration
	always_ff @(posedge PT_CK) begin
		if (!RESET_N) begin
			slave_address <= '0;
			div           <= DIV_RESET;
		end else if (reg_wr) begin
			if (reg_addr == i2c_pkg::reg_slave)
				slave_address <= reg_wdata[6:0];
			if (reg_addr == i2c_pkg::reg_div)
				div <= reg_wdata[i2c_pkg::DIV_W-1:0];
		end
	end

	always_ff @(posedge PT_CK) begin
		if (!RESET_N) begin
			go <= 1'b0;
			op <= i2c_pkg::op_read;
		end else if (end_ok && busy) begin
			go <= 1'b0; // master picked it up
		end else if (start_wr) begin
			go <= 1'b1;
			op <= i2c_pkg::i2c_op_t'(reg_wdata[1]);
		end
	end

	// result capture on end_ok rise
	always_ff @(posedge PT_CK) begin
		if (!RESET_N) begin
			end_ok_q <= 1'b1;
			done     <= 1'b0;
			ack_q    <= 1'b0;
			sample   <= '0;
		end else begin
			end_ok_q <= end_ok;
			if (end_rise) begin
				done   <= 1'b1;
				ack_q  <= ack_ok;
				sample <= data16;
			end else if (reg_rd && reg_addr == i2c_pkg::reg_ctrl) begin
				done <= 1'b0; // cleared by status read
			end
		end
	end

	always_comb begin
		rd_mux = '0;
		case (reg_addr)
			i2c_pkg::reg_ctrl:  rd_mux[2:0] = {done, ack_q, busy};
			i2c_pkg::reg_slave: rd_mux[6:0] = slave_address;
			i2c_pkg::reg_div:   rd_mux[i2c_pkg::DIV_W-1:0] = div;
			default:            rd_mux = sample;
		endcase
	end

	always_ff @(posedge PT_CK) begin
		if (!RESET_N)
			reg_rdata <= '0;
		else if (reg_rd)
			reg_rdata <= rd_mux;
	end

endmodule

`default_nettype wire

// File: verilog/i2c_sensor_top.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_sensor_top #(
	parameter logic [i2c_pkg::DIV_W-1:0] DIV_RESET = 16'd24
) (
	input  wire                        PT_CK,
	input  wire                        RESET_N,
	input  wire                        reg_wr,
	input  wire                        reg_rd,
	input  wire i2c_pkg::reg_addr_t    reg_addr,
	input  wire [i2c_pkg::REG_W-1:0]   reg_wdata,
	output logic [i2c_pkg::REG_W-1:0]  reg_rdata,
	input  wire                        sdai,
	output logic                       sdao,
	output logic                       sclo
);

	logic                       go;
	logic                       end_ok;
	logic                       busy;
	logic                       ack_ok;
	logic                       step;
	logic [i2c_pkg::REG_W-1:0]  data16;
	logic [6:0]                 slave_address;
	logic [i2c_pkg::DIV_W-1:0]  div;
	i2c_pkg::i2c_op_t           op;

	sensor_regs #(
		.DIV_RESET(DIV_RESET)
	) sensor_regs_inst (
		.PT_CK(PT_CK), .RESET_N(RESET_N),
		.reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
		.end_ok(end_ok), .busy(busy), .data16(data16), .ack_ok(ack_ok),
		.go(go), .op(op), .slave_address(slave_address), .div(div)
	);

	i2c_bit_timer i2c_bit_timer_inst (
		.PT_CK(PT_CK), .RESET_N(RESET_N),
		.enable(busy), // runs whenever the master is out of idle
		.div(div), .step(step)
	);

	i2c_read_master i2c_read_master_inst (
		.PT_CK(PT_CK), .RESET_N(RESET_N),
		.step(step), .go(go), .op(op), .slave_address(slave_address),
		.sdai(sdai), .sdao(sdao), .sclo(sclo),
		.end_ok(end_ok), .ack_ok(ack_ok), .data16(data16), .busy(busy)
	);

endmodule

`default_nettype wire

// File: testbench/i2c_slave_model.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_slave_model (
	input  wire         scl,
	input  wire         sda,
	input  wire  [6:0]  own_address,
	input  wire  [15:0] tx_data,
	input  wire         ack_en,
	output logic        sda_rel,
	output int          start_cnt,
	output int          stop_cnt,
	output int          data_bits,
	output logic        rw_bit,
	output logic        mack0,
	output logic        mack1
);

	logic       scl_q = 1'b1;
	logic       sda_q = 1'b1;
	logic       rel = 1'b1;
	logic       hit = 1'b0;
	logic       rw_r = 1'b0;
	logic       mack0_r = 1'b1;
	logic       mack1_r = 1'b1;
	logic [7:0] sh = '0;
	int         n = 0;       // scl rises since start
	int         k;
	int         starts = 0;
	int         stops = 0;
	int         bits = 0;

	assign sda_rel   = rel;
	assign start_cnt = starts;
	assign stop_cnt  = stops;
	assign data_bits = bits;
	assign rw_bit    = rw_r;
	assign mack0     = mack0_r;
	assign mack1     = mack1_r;

	always @(scl or sda) begin
		if (scl && scl_q && sda_q && !sda) begin
			starts = starts + 1; // start
			n = 0;
			bits = 0;
			hit = 1'b0;
			mack0_r = 1'b1; // opposite of a good ack pattern
			mack1_r = 1'b0;
			rel <= 1'b1;
		end else if (scl && scl_q && !sda_q && sda) begin
			stops = stops + 1; // stop
			rel <= 1'b1;
		end else if (scl && !scl_q) begin
			n = n + 1;
			if (n <= 8)
				sh = {sh[6:0], sda};
			if (n == 8) begin
				hit = (sh[7:1] == own_address);
				rw_r = sh[0];
			end
			if (n == 18)
				mack0_r = sda; // master ack after byte 0
			if (n == 27)
				mack1_r = sda;
		end else if (!scl && scl_q) begin
			if ((n >= 10 && n <= 17) || (n >= 19 && n <= 26))
				bits = bits + 1; // data clock completed
			rel <= 1'b1;
			if (n == 8 && hit && ack_en) begin
				rel <= 1'b0; // address ack
			end else if (n >= 9 && n <= 25 && hit && ack_en && rw_r) begin
				k = n - 9;
				if (k < 8)
					rel <= tx_data[15-k];
				else if (k >= 9)
					rel <= tx_data[16-k];
			end
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

`default_nettype wire

// File: testbench/tb_i2c_sensor.sv
`timescale 1ns/10ps
`default_nettype none

module tb_i2c_sensor;

	localparam logic [15:0] DIV_RESET = 16'd24;

	logic                      PT_CK;
	logic                      RESET_N;
	logic                      reg_wr;
	logic                      reg_rd;
	i2c_pkg::reg_addr_t        reg_addr;
	logic [i2c_pkg::REG_W-1:0] reg_wdata;
	logic [i2c_pkg::REG_W-1:0] reg_rdata;
	wire                       sdao;
	wire                       sclo;
	wire                       sda_rel;
	wire                       sda;
	logic [15:0]               model_data;
	logic                      model_ack_en;
	int                        start_cnt, stop_cnt, data_bits;
	logic                      rw_bit, mack0, mack1;
	logic [31:0]               lfsr = 32'h22b8;
	int                        err_data = 0;
	int                        err_status = 0;
	int                        err_proto = 0;
	int                        err_run = 0;

	assign sda = sdao & sda_rel; // open drain bus

	i2c_sensor_top #(.DIV_RESET(DIV_RESET)) i2c_sensor_top_inst (
		.PT_CK(PT_CK), .RESET_N(RESET_N), .reg_wr(reg_wr), .reg_rd(reg_rd),
		.reg_addr(reg_addr), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
		.sdai(sda), .sdao(sdao), .sclo(sclo)
	);

	i2c_slave_model slave (
		.scl(sclo), .sda(sda), .own_address(7'h48), .tx_data(model_data),
		.ack_en(model_ack_en), .sda_rel(sda_rel), .start_cnt(start_cnt),
		.stop_cnt(stop_cnt), .data_bits(data_bits), .rw_bit(rw_bit),
		.mack0(mack0), .mack1(mack1)
	);

	initial begin
		PT_CK = 1'b0;
		forever #20 PT_CK = ~PT_CK;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic idle_gap();
		int n;
		n = 0;
		repeat (3) begin
			n = (n << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
		repeat (n) @(posedge PT_CK);
	endtask

	task automatic check_data(input string name, input logic [i2c_pkg::REG_W-1:0] got,
			input logic [i2c_pkg::REG_W-1:0] exp);
		if (got !== exp) begin
			err_data++;
			$display("mismatch %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			err_status++;
			$display("mismatch %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_event(input string name, input int got, input int exp);
		if (got != exp) begin
			err_proto++;
			$display("mismatch %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic reg_write(input i2c_pkg::reg_addr_t a, input logic [15:0] d);
		@(posedge PT_CK);
		reg_wr    <= 1'b1;
		reg_addr  <= a;
		reg_wdata <= d;
		@(posedge PT_CK);
		reg_wr <= 1'b0;
	endtask

	task automatic reg_read(input i2c_pkg::reg_addr_t a, output logic [15:0] d);
		@(posedge PT_CK);
		reg_rd   <= 1'b1;
		reg_addr <= a;
		@(posedge PT_CK);
		reg_rd <= 1'b0;
		@(negedge PT_CK);
		d = reg_rdata;
	endtask

	task automatic wait_busy(output logic ok);
		logic [15:0] st;
		int polls;
		polls = 0;
		st = '0;
		while (!st[0] && polls < 200) begin
			reg_read(i2c_pkg::reg_ctrl, st);
			polls++;
		end
		ok = st[0];
		if (!ok) begin
			err_run++;
			$display("timeout: master never reported busy");
		end
	endtask

	task automatic wait_done(output logic [15:0] st, output logic ok);
		int polls;
		polls = 0;
		st = '0;
		while (!st[2] && polls < 20000) begin
			reg_read(i2c_pkg::reg_ctrl, st);
			polls++;
		end
		ok = st[2];
		if (!ok) begin
			err_run++;
			$display("timeout: transaction never finished");
		end
	endtask

	initial begin
		int fd;
		int s0, p0;
		string line;
		logic ok;
		logic [15:0] rd, st;
		logic [15:0] f_op, f_addr, f_div, f_sd, f_ack, f_exp, f_eack;
		RESET_N = 1'b0;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = i2c_pkg::reg_ctrl;
		reg_wdata = '0;
		model_data = '0;
		model_ack_en = 1'b0;
		repeat (10) @(posedge PT_CK);
		RESET_N <= 1'b1;
		@(negedge PT_CK);
		check_bit("sclo", sclo, 1'b1);
		check_bit("sdao", sdao, 1'b1);
		reg_read(i2c_pkg::reg_ctrl, rd);
		check_bit("busy", rd[0], 1'b0);
		check_bit("done", rd[2], 1'b0);
		reg_read(i2c_pkg::reg_div, rd);
		check_data("reg_div", rd, DIV_RESET);

		fd = $fopen("testbench/sensor_vectors.txt", "r");
		if (fd == 0) begin
			err_run++;
			$display("cannot open testbench/sensor_vectors.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line[0] == "#")
					continue;
				if ($sscanf(line, "%h %h %h %h %h %h %h", f_op, f_addr, f_div, f_sd,
						f_ack, f_exp, f_eack) != 7)
					continue;
				model_data = f_sd;
				model_ack_en = f_ack[0];
				reg_write(i2c_pkg::reg_slave, f_addr);
				idle_gap();
				reg_read(i2c_pkg::reg_slave, rd);
				check_data("reg_slave", rd, {9'd0, f_addr[6:0]});
				reg_write(i2c_pkg::reg_div, f_div);
				idle_gap();
				s0 = start_cnt;
				p0 = stop_cnt;
				reg_write(i2c_pkg::reg_ctrl, {14'd0, f_op[0], 1'b1});
				wait_busy(ok);
				if (!ok)
					break;
				reg_write(i2c_pkg::reg_ctrl, {14'd0, f_op[0], 1'b1}); // dropped while busy
				wait_done(st, ok);
				if (!ok)
					break;
				check_bit("ack_ok", st[1], f_eack[0]);
				reg_read(i2c_pkg::reg_ctrl, st);
				check_bit("done after clear", st[2], 1'b0);
				idle_gap();
				reg_read(i2c_pkg::reg_data, rd);
				check_data("reg_data", rd, f_exp);
				check_event("start count", start_cnt - s0, 1);
				check_event("stop count", stop_cnt - p0, 1);
				check_event("rw bit", int'(rw_bit), f_op[0] ? 0 : 1);
				check_event("data bits", data_bits, f_op[0] ? 0 : 16);
				if (!f_op[0]) begin
					check_event("master ack byte 0", int'(mack0), 0);
					check_event("master ack byte 1", int'(mack1), 1);
				end
			end
			$fclose(fd);
		end

		$display("errors: data %0d, status %0d, protocol %0d, run %0d", err_data,
			err_status, err_proto, err_run);
		if (err_data + err_status + err_proto + err_run == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
verilog/i2c_pkg.sv
verilog/i2c_bit_timer.sv
verilog/i2c_read_master.sv
verilog/sensor_regs.sv
verilog/i2c_sensor_top.sv
testbench/i2c_slave_model.sv
testbench/tb_i2c_sensor.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the I2C sensor testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "cannot enter project root"
	exit 1
fi

verilator --binary --timing -f list.f --top-module tb_i2c_sensor -o tb_i2c_sensor
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_i2c_sensor)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

// File: testbench/sensor_vectors.txt
# op(0 read,1 probe) slave_addr div slave_data slave_ack_en exp_data exp_ack
# all fields hex, the model answers at address 48
0 48 0004 a55a 1 a55a 1
0 48 0002 1234 1 1234 1
0 31 0003 beef 1 ffff 0
1 48 0002 0000 1 ffff 1
1 22 0002 0000 1 ffff 0
0 48 0001 8001 1 8001 1
0 48 0005 7e3c 0 ffff 0
1 48 0003 0000 0 ffff 0
0 48 0000 c3d2 1 c3d2 1
1 48 0000 0000 1 ffff 1
0 48 0007 00ff 1 00ff 1
0 49 0002 5a5a 1 ffff 0
